// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -Wno-fatal -f project.f --top-module fpuExWideTb \
		-Mdir obj_dir -o fpuExWideTb
	./obj_dir/fpuExWideTb | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== project.f ====
+incdir+include
verilog/fpuPkg.sv
verilog/fpuWiden.sv
verilog/fpuNarrow.sv
verilog/fpuIssue.sv
verilog/fpuFormatUnit.sv
verilog/fpuExWide.sv
tests/fpuExWideTb.sv

// ==== include/fpuTbModel.svh ====
// FP conversion reference model
`ifndef FPU_TB_MODEL_SVH
`define FPU_TB_MODEL_SVH

// narrow word to double with subnormals flushed
function automatic logic [63:0] modelWiden(input logic [31:0] src, input int expW,
		input int fracW);
	logic        sign;
	int          e;
	logic [51:0] f;
	sign = src[expW + fracW];
	e    = int'(src >> fracW) & ((1 << expW) - 1);
	f    = 52'(src & ((32'd1 << fracW) - 1)) << (52 - fracW);
	if (e == 0) return {sign, 63'b0};
	if (e == (1 << expW) - 1) return {sign, 11'h7ff, (f != 0) ? (f | 52'h8000000000000) : f};
	return {sign, 11'(e - ((1 << (expW - 1)) - 1) + 1023), f};
endfunction

// truncating double to narrow word
function automatic logic [31:0] modelNarrow(input logic [63:0] d, input int expW,
		input int fracW);
	int          e;
	int          adj;
	int          maxE;
	logic [31:0] ft;
	logic [31:0] r;
	e    = int'(d[62:52]);
	maxE = (1 << expW) - 1;
	ft   = 32'(d[51:0] >> (52 - fracW));
	adj  = e - 1023 + (1 << (expW - 1)) - 1;
	if (e == 2047) begin
		r = 32'(maxE) << fracW;
		if (d[51:0] != 0) r = r | ft | (32'd1 << (fracW - 1)); // NaN keeps top bit
	end else if (adj >= maxE) begin
		r = 32'(maxE) << fracW;
	end else if (adj <= 0) begin
		r = 0;
	end else begin
		r = (32'(adj) << fracW) | ft;
	end
	return r | (32'(d[63]) << (expW + fracW));
endfunction

// expected result is zero unless status is OK
function automatic logic [63:0] modelResult(input logic [5:0] op, input logic [8:0] ixt,
		input logic [63:0] rs, input logic en);
	logic [31:0] w;
	logic [31:0] dHalf;
	w     = ixt[3] ? rs[63:32] : rs[31:0];
	dHalf = modelNarrow(rs, 5, 10);
	if (!en) return 64'b0;
	if (op == fpuPkg::FpuOpFpu3 && ixt[3:0] == 4'h4) return rs;
	if (op == fpuPkg::FpuOpFldcx && ixt[2:0] == 3'h0) return modelWiden(w, 8, 23);
	if (op == fpuPkg::FpuOpFldcx && ixt[2:0] == 3'h1) return rs;
	if (op == fpuPkg::FpuOpFldcx && ixt[2:0] == 3'h3)
		return modelWiden({16'b0, w[15:0]}, 5, 10);
	if (op == fpuPkg::FpuOpFstcx && ixt[3:0] == 4'h0) return {32'b0, modelNarrow(rs, 8, 23)};
	if (op == fpuPkg::FpuOpFstcx && ixt[3:0] == 4'h1) return rs;
	if (op == fpuPkg::FpuOpFstcx && ixt[3:0] == 4'h3) return {48'b0, dHalf[15:0]};
	if (op == fpuPkg::FpuOpFstcx && ixt[3:0] == 4'h8) return {modelNarrow(rs, 8, 23), rs[31:0]};
	return 64'b0;
endfunction

`endif

// ==== tests/fpuExWideTb.sv ====
// FP slice testbench
`default_nettype none

module fpuExWideTb import fpuPkg::*; ();

	`include "fpuTbModel.svh"

	localparam int TimeoutCycles = 2000;    // tests need about 300
	localparam laneReqT IdleLane = '0;      // nop, no FP command

	logic        clock = 1'b0;
	logic        reset;
	laneReqT     laneA;
	laneReqT     laneB;
	logic        statusT;
	logic        braFlush;
	logic        exHold;
	logic [63:0] result;
	fpuStatusT   status;
	int          seed = 32'h91d8;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;

	fpuExWide #(.LaneBEnable(1'b1)) i_dut (
		.clock(clock), .reset(reset), .laneA(laneA), .laneB(laneB), .statusT(statusT),
		.braFlush(braFlush), .exHold(exHold), .result(result), .status(status)
	);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TimeoutCycles) begin
			$display("timeout: tests still running after %0d cycles", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	function automatic laneReqT makeReq(input fpuCcT cc, input logic [5:0] op,
			input logic [8:0] ixt, input logic [63:0] rs);
		laneReqT r;
		r.cmd.cc     = cc;
		r.cmd.opcode = op;
		r.ixt        = ixt;
		r.rs         = rs;
		return r;
	endfunction

	// predicate rule, flush always wins
	function automatic logic ccPass(input fpuCcT cc, input logic t, input logic flush);
		if (flush) return 1'b0;
		case (cc)
			CcAlways: return 1'b1;
			CcNever:  return 1'b0;
			CcIfTrue: return t;
			default:  return !t;
		endcase
	endfunction

	function automatic logic keptOp(input logic [5:0] op, input logic [8:0] ixt);
		case (op)
			FpuOpFldcx: return ixt[2:0] inside {3'd0, 3'd1, 3'd3};
			FpuOpFstcx: return ixt[3:0] inside {4'd0, 4'd1, 4'd3, 4'd8};
			FpuOpFpu3:  return ixt[3:0] == 4'd4;
			default:    return 1'b0;
		endcase
	endfunction

	function automatic logic [63:0] randDouble();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic checkOut(input logic [63:0] expRes, input fpuStatusT expSt);
		checks += 2;
		assert (result === expRes) else begin
			errors++;
			$display("error at %0t: result expected %h, got %h", $time, expRes, result);
		end
		assert (status === expSt) else begin
			errors++;
			$display("error at %0t: status expected %0d, got %0d", $time, expSt, status);
		end
	endtask

	// called 2 units after an edge; returns 2 units after the accepting edge
	task automatic stepCycle(input laneReqT a, input laneReqT b, input logic t,
			input logic flush, input logic hold);
		laneA    = a;
		laneB    = b;
		statusT  = t;
		braFlush = flush;
		exHold   = hold;
		@(posedge clock);
		#2;
	endtask

	task automatic issueAndCheck(input laneReqT a, input logic t, input logic flush);
		logic en;
		en = ccPass(a.cmd.cc, t, flush);
		stepCycle(a, IdleLane, t, flush, 1'b0);
		checkOut(modelResult(a.cmd.opcode, a.ixt, a.rs, en),
			(en && keptOp(a.cmd.opcode, a.ixt)) ? FpuOk : FpuReady);
	endtask

	task automatic testReset();
		reset = 1'b1;
		repeat (3) @(posedge clock);
		#2;
		reset = 1'b0;
		checkOut(64'h0, FpuReady);
		stepCycle(IdleLane, IdleLane, 1'b1, 1'b0, 1'b0);
		checkOut(64'h0, FpuReady);
	endtask

	task automatic testWiden();
		logic [31:0] singleSpecial [6];
		logic [15:0] halfSpecial [6];
		logic [63:0] rs;
		logic [8:0]  ixt;
		singleSpecial = '{32'h0, 32'h80000000, 32'h00012345, 32'h7f800000,
			32'hff800001, 32'h7fc00000};
		halfSpecial = '{16'h0, 16'h8000, 16'h0123, 16'h7c00, 16'hfc01, 16'h7e00};
		for (int m = 0; m < 2; m++) begin
			for (int up = 0; up < 2; up++) begin
				ixt = {5'b0, up[0], (m == 1) ? FxCvtHalf[2:0] : FxCvtSingle[2:0]};
				for (int i = 0; i < 16; i++) begin
					rs = randDouble();
					if (i < 6 && m == 0 && up == 1) rs[63:32] = singleSpecial[i];
					if (i < 6 && m == 0 && up == 0) rs[31:0] = singleSpecial[i];
					if (i < 6 && m == 1 && up == 1) rs[47:32] = halfSpecial[i];
					if (i < 6 && m == 1 && up == 0) rs[15:0] = halfSpecial[i];
					issueAndCheck(makeReq(CcAlways, FpuOpFldcx, ixt, rs), 1'b0, 1'b0);
				end
			end
		end
		// moves return Rs untouched
		rs = randDouble();
		stepCycle(makeReq(CcAlways, FpuOpFldcx, 9'h9, rs), IdleLane, 1'b0, 1'b0, 1'b0);
		checkOut(rs, FpuOk);
		stepCycle(makeReq(CcAlways, FpuOpFstcx, 9'h1, ~rs), IdleLane, 1'b0, 1'b0, 1'b0);
		checkOut(~rs, FpuOk);
		stepCycle(makeReq(CcAlways, FpuOpFpu3, 9'h4, rs), IdleLane, 1'b0, 1'b0, 1'b0);
		checkOut(rs, FpuOk);
	endtask

	task automatic testNarrow();
		logic [63:0] special [8];
		logic [3:0]  modes [3];
		logic [63:0] rs;
		modes   = '{FxCvtSingle, FxCvtHalf, FxPack};
		special = '{64'h0, 64'h8000000000000001, 64'h47f0000000000000, 64'hc100000000000000,
			64'h3800000000000000, 64'h7ff0000000000001, 64'hfff0000000000000,
			64'h3ff5555555555555};
		for (int m = 0; m < 3; m++) begin
			for (int i = 0; i < 20; i++) begin
				rs = randDouble();
				if (i < 8) rs = special[i];
				else if (i < 14) rs[62:52] = 11'(1008 + ($unsigned($random(seed)) % 32));
				issueAndCheck(makeReq(CcAlways, FpuOpFstcx, {5'b0, modes[m]}, rs), 1'b0, 1'b0);
			end
		end
		for (int i = 0; i < 3; i++) begin
			stepCycle(makeReq(CcAlways, FpuOpFstcx, {5'b0, 4'h2 + 4'(i * 5)}, randDouble()),
				IdleLane, 1'b0, 1'b0, 1'b0);
			checkOut(64'h0, FpuReady); // unsupported mode
		end
	endtask

	task automatic testPredication();
		for (int c = 0; c < 4; c++) begin
			for (int t = 0; t < 2; t++) begin
				issueAndCheck(makeReq(fpuCcT'(c), FpuOpFpu3, 9'h4, randDouble()), t[0], 1'b0);
				issueAndCheck(makeReq(fpuCcT'(c), FpuOpFstcx, 9'h0, randDouble()), t[0], 1'b0);
			end
		end
		issueAndCheck(makeReq(CcAlways, FpuOpFpu3, 9'h4, randDouble()), 1'b1, 1'b1);
		issueAndCheck(makeReq(CcIfTrue, FpuOpFldcx, 9'h3, randDouble()), 1'b1, 1'b1);
	endtask

	task automatic testLanes();
		logic [63:0] rsA;
		logic [63:0] rsB;
		rsA = randDouble();
		rsB = randDouble();
		stepCycle(makeReq(CcAlways, FpuOpFstcx, 9'h1, rsA),
			makeReq(CcAlways, FpuOpFpu3, 9'h4, rsB), 1'b0, 1'b0, 1'b0);
		checkOut(rsA, FpuOk);
		stepCycle(IdleLane, makeReq(CcAlways, FpuOpFpu3, 9'h4, rsB), 1'b0, 1'b0, 1'b0);
		checkOut(rsB, FpuOk);
		stepCycle(makeReq(CcNever, FpuOpFpu3, 9'h4, rsA),
			makeReq(CcAlways, FpuOpFpu3, 9'h4, rsB), 1'b0, 1'b0, 1'b0);
		checkOut(64'h0, FpuReady); // lane A still owns the slot
		stepCycle(makeReq(CcAlways, 6'h13, 9'h4, rsA), makeReq(CcAlways, 6'h05, 9'h4, rsB),
			1'b1, 1'b0, 1'b0);
		checkOut(64'h0, FpuReady);
	endtask

	task automatic testHold();
		logic [63:0] rsA;
		logic [63:0] rsB;
		laneReqT     second;
		rsA    = randDouble();
		rsB    = randDouble();
		second = makeReq(CcAlways, FpuOpFstcx, 9'h1, rsB);
		stepCycle(makeReq(CcIfTrue, FpuOpFpu3, 9'h4, rsA), IdleLane, 1'b1, 1'b0, 1'b0);
		checkOut(rsA, FpuOk);
		// T drops and flush rises while frozen
		for (int i = 0; i < 3; i++) begin
			stepCycle(second, second, 1'b0, 1'b1, 1'b1);
			checkOut(rsA, FpuOk);
		end
		stepCycle(second, IdleLane, 1'b0, 1'b0, 1'b0);
		checkOut(rsB, FpuOk);
	endtask

	initial begin
		reset    = 1'b1;
		laneA    = IdleLane;
		laneB    = IdleLane;
		statusT  = 1'b0;
		braFlush = 1'b0;
		exHold   = 1'b0;
		testReset();
		testWiden();
		testNarrow();
		testPredication();
		testLanes();
		testHold();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/fpuExWide.sv ====
// Two-lane FP format slice
`default_nettype none

module fpuExWide import fpuPkg::*; #(
	parameter bit LaneBEnable = 1'b1
) (
	input  wire          clock,
	input  wire          reset,
	input  wire laneReqT laneA,
	input  wire laneReqT laneB,
	input  wire          statusT,
	input  wire          braFlush,
	input  wire          exHold,
	output logic [63:0]  result,
	output fpuStatusT    status
);

	issuedOpT issued; // latched command into the converters

	fpuIssue #(
		.LaneBEnable(LaneBEnable)
	) issueStage (
		.clock   (clock),
		.reset   (reset),
		.laneA   (laneA),
		.laneB   (laneB),
		.statusT (statusT),
		.braFlush(braFlush),
		.exHold  (exHold),
		.issued  (issued)
	);

	fpuFormatUnit formatUnit (
		.issued(issued),
		.result(result),
		.status(status)
	);

endmodule

`default_nettype wire

// ==== verilog/fpuFormatUnit.sv ====
// FP format conversion unit
`default_nettype none

module fpuFormatUnit import fpuPkg::*; (
	input  wire issuedOpT issued,
	output logic [63:0]   result,
	output fpuStatusT     status
);

	logic [31:0] srcWord;
	logic [63:0] s2dVal;
	logic [63:0] h2dVal;
	logic [31:0] d2sVal;
	logic [15:0] d2hVal;
	logic [63:0] cnvVal;
	logic        cnvKept;
	logic        doResult;

	// index bit 3 picks the upper word of Rs
	assign srcWord = issued.ixt[3] ? issued.rs[63:32] : issued.rs[31:0];

	fpuWiden #(
		.ExpWidth (ExpSingle),
		.FracWidth(FracSingle)
	) widenSingle (
		.narrow(srcWord),
		.wide  (s2dVal)
	);

	fpuWiden #(
		.ExpWidth (ExpHalf),
		.FracWidth(FracHalf)
	) widenHalf (
		.narrow(srcWord[15:0]),
		.wide  (h2dVal)
	);

	fpuNarrow #(
		.ExpWidth (ExpSingle),
		.FracWidth(FracSingle)
	) narrowSingle (
		.wide  (issued.rs),
		.narrow(d2sVal)
	);

	fpuNarrow #(
		.ExpWidth (ExpHalf),
		.FracWidth(FracHalf)
	) narrowHalf (
		.wide  (issued.rs),
		.narrow(d2hVal)
	);

	always_comb begin
		cnvVal  = '0;
		cnvKept = 1'b0;
		case (issued.opcode)
			FpuOpFldcx: begin
				// mode sits in bits 2..0 here
				cnvKept = 1'b1;
				case (issued.ixt[2:0])
					FxCvtSingle[2:0]: cnvVal = s2dVal;
					FxMove[2:0]:      cnvVal = issued.rs;
					FxCvtHalf[2:0]:   cnvVal = h2dVal;
					default:          cnvKept = 1'b0;
				endcase
			end
			FpuOpFstcx: begin
				cnvKept = 1'b1;
				case (issued.ixt[3:0])
					FxCvtSingle: cnvVal = {32'b0, d2sVal};
					FxMove:      cnvVal = issued.rs;
					FxCvtHalf:   cnvVal = {48'b0, d2hVal};
					FxPack:      cnvVal = {d2sVal, issued.rs[31:0]}; // above old low word
					default:     cnvKept = 1'b0;
				endcase
			end
			FpuOpFpu3: begin
				if (issued.ixt[3:0] == FxMoveFpu3) begin
					cnvKept = 1'b1;
					cnvVal  = issued.rs;
				end
			end
			default: begin
			end
		endcase
	end

	assign doResult = issued.enable && cnvKept;
	assign result   = doResult ? cnvVal : '0;
	assign status   = doResult ? FpuOk : FpuReady;

endmodule

`default_nettype wire

// ==== verilog/fpuIssue.sv ====
// FP command issue stage
`default_nettype none

module fpuIssue import fpuPkg::*; #(
	parameter bit LaneBEnable = 1'b1
) (
	input  wire          clock,
	input  wire          reset,
	input  wire laneReqT laneA,
	input  wire laneReqT laneB,
	input  wire          statusT,
	input  wire          braFlush,
	input  wire          exHold,
	output issuedOpT     issued
);

	logic        laneAFp;
	logic        laneBFp;
	logic        pickB;
	laneReqT     selReq;

	fpuCmdT      cmdL;
	logic [8:0]  ixtL;
	logic [63:0] rsL;
	logic        srTL;
	logic        flushL;
	logic        ccEnable;

	function automatic logic isFpOp(input logic [5:0] op);
		return (op == FpuOpFpu3) || (op == FpuOpFldcx) || (op == FpuOpFstcx);
	endfunction

	assign laneAFp = isFpOp(laneA.cmd.opcode);
	assign laneBFp = isFpOp(laneB.cmd.opcode);
	assign pickB   = LaneBEnable && laneBFp && !laneAFp; // lane A wins
	assign selReq  = pickB ? laneB : laneA;

	// command and flush state, reset to a nop that never executes
	always_ff @(posedge clock) begin
		if (reset) begin
			cmdL   <= '{cc: CcNever, opcode: FpuOpNop};
			flushL <= 1'b0;
		end else if (!exHold) begin
			cmdL.cc     <= selReq.cmd.cc;
			cmdL.opcode <= (laneAFp || pickB) ? selReq.cmd.opcode : FpuOpNop;
			flushL      <= braFlush;
		end
	end

	// operands ride along with the command
	always_ff @(posedge clock) begin
		if (!exHold) begin
			ixtL <= selReq.ixt;
			rsL  <= selReq.rs;
			srTL <= statusT;    // SR.T sampled with the command
		end
	end

	// predication from the condition code
	always_comb begin
		case (cmdL.cc)
			CcAlways: ccEnable = 1'b1;
			CcNever:  ccEnable = 1'b0;
			CcIfTrue: ccEnable = srTL;
			default:  ccEnable = !srTL;
		endcase
	end

	assign issued = '{
		opcode: cmdL.opcode,
		ixt:    ixtL,
		rs:     rsL,
		enable: !flushL && ccEnable
	};

endmodule

`default_nettype wire

// ==== verilog/fpuNarrow.sv ====
// Double to narrow float
`default_nettype none

module fpuNarrow import fpuPkg::*; #(
	parameter int ExpWidth  = 8,
	parameter int FracWidth = 23
) (
	input  wire  [63:0]                 wide,
	output logic [ExpWidth+FracWidth:0] narrow
);

	localparam int NarrowBias = (1 << (ExpWidth - 1)) - 1;
	localparam int AdjWidth   = ExpDouble + 2;     // room for sign and overflow

	localparam logic signed [AdjWidth-1:0] RebiasOfs = AdjWidth'(BiasDouble - NarrowBias);
	localparam logic signed [AdjWidth-1:0] ExpMax    = AdjWidth'((1 << ExpWidth) - 1);

	logic                       sign;
	logic [ExpDouble-1:0]       expIn;
	logic [FracDouble-1:0]      fracIn;
	logic [FracWidth-1:0]       fracTrunc;
	logic signed [AdjWidth-1:0] expAdj;

	assign sign      = wide[63];
	assign expIn     = wide[FracDouble +: ExpDouble];
	assign fracIn    = wide[FracDouble-1:0];
	assign fracTrunc = fracIn[FracDouble-1 -: FracWidth]; // low bits dropped
	assign expAdj    = $signed({2'b00, expIn}) - RebiasOfs;

	always_comb begin
		if (&expIn) begin
			// inf or NaN of the double
			narrow = {sign, {ExpWidth{1'b1}}, fracTrunc};
			if (fracIn != '0) begin
				// payload may sit below the kept bits
				narrow[FracWidth-1] = 1'b1;
			end
		end else if (expAdj >= ExpMax) begin
			narrow = {sign, {ExpWidth{1'b1}}, {FracWidth{1'b0}}}; // overflow to inf
		end else if (expAdj <= 0) begin
			narrow = {sign, {(ExpWidth + FracWidth){1'b0}}};   // underflow to zero
		end else begin
			narrow = {sign, expAdj[ExpWidth-1:0], fracTrunc};
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fpuPkg.sv ====
// FP execute slice definitions
`default_nettype none

package fpuPkg;

	// micro-op codes, low six bits of a command
	localparam logic [5:0] FpuOpNop   = 6'h00;
	localparam logic [5:0] FpuOpFpu3  = 6'h20;
	localparam logic [5:0] FpuOpFldcx = 6'h21;
	localparam logic [5:0] FpuOpFstcx = 6'h22;

	typedef enum logic [1:0] {
		CcAlways  = 2'b00,
		CcNever   = 2'b01,
		CcIfTrue  = 2'b10,
		CcIfFalse = 2'b11
	} fpuCcT;

	typedef struct packed {
		fpuCcT      cc;
		logic [5:0] opcode;
	} fpuCmdT;

	typedef struct packed {
		fpuCmdT      cmd;
		logic [8:0]  ixt;    // index / opcode extension
		logic [63:0] rs;
	} laneReqT;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [8:0]  ixt;
		logic [63:0] rs;
		logic        enable; // predicate passed and no flush
	} issuedOpT;

	typedef enum logic [1:0] {
		FpuReady = 2'b00,
		FpuOk    = 2'b01,
		FpuHold  = 2'b10     // reserved for multi-cycle ops
	} fpuStatusT;

	// IEEE format fields
	localparam int ExpDouble  = 11;
	localparam int FracDouble = 52;
	localparam int BiasDouble = 1023;
	localparam int ExpSingle  = 8;
	localparam int FracSingle = 23;
	localparam int ExpHalf    = 5;
	localparam int FracHalf   = 10;

	// index mode codes for FLDCX / FSTCX
	localparam logic [3:0] FxCvtSingle = 4'h0;
	localparam logic [3:0] FxMove      = 4'h1;
	localparam logic [3:0] FxCvtHalf   = 4'h3;
	localparam logic [3:0] FxPack      = 4'h8;
	localparam logic [3:0] FxMoveFpu3  = 4'h4;

endpackage

`default_nettype wire

// ==== verilog/fpuWiden.sv ====
// Narrow float to double
`default_nettype none

module fpuWiden import fpuPkg::*; #(
	parameter int ExpWidth  = 8,
	parameter int FracWidth = 23
) (
	input  wire  [ExpWidth+FracWidth:0] narrow,
	output logic [63:0]                 wide
);

	localparam int NarrowBias = (1 << (ExpWidth - 1)) - 1;
	localparam int PadWidth   = FracDouble - FracWidth;
	localparam logic [ExpDouble-1:0] RebiasOfs = ExpDouble'(BiasDouble - NarrowBias);

	logic                  sign;
	logic [ExpWidth-1:0]   expIn;
	logic [FracWidth-1:0]  fracIn;
	logic [FracDouble-1:0] fracOut;
	logic [ExpDouble-1:0]  expOut;

	assign sign    = narrow[ExpWidth+FracWidth];
	assign expIn   = narrow[FracWidth +: ExpWidth];
	assign fracIn  = narrow[FracWidth-1:0];
	assign fracOut = {fracIn, {PadWidth{1'b0}}}; // left aligned, exact
	assign expOut  = ExpDouble'(expIn) + RebiasOfs;

	always_comb begin
		if (expIn == '0) begin
			// zero, subnormals flush too
			wide = {sign, 63'b0};
		end else if (&expIn) begin
			wide = {sign, {ExpDouble{1'b1}}, fracOut};
			if (fracIn != '0) begin
				wide[FracDouble-1] = 1'b1; // NaN comes out quiet
			end
		end else begin
			wide = {sign, expOut, fracOut};
		end
	end

endmodule

`default_nettype wire
